// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module fetch_tb -f project.f
	-./obj_dir/Vfetch_tb +verilator+error+limit+100 > sim.log 2>&1
	cat sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: project.f
src/fetch_pkg.sv
src/isram_pkg.sv
src/redirect_hold.sv
src/fetch_cancel.sv
src/fetch_stage.sv
src/fetch_top.sv
verification/fetch_checker.sv
verification/fetch_tb.sv

// File: src/fetch_cancel.sv
`timescale 1ns/1ps

module fetch_cancel (
    input  logic clk,
    input  logic resetn,
    input  logic redirect_now,
    // an accepted fetch has not returned yet
    input  logic inflight,
    input  logic isram_data_ok,
    output logic resp_drop
);
    import isram_pkg::*;

    logic [OUTSTANDING_W-1:0] stale_cnt_q;
    logic                     stale_pending;
    logic                     mark_stale;
    logic                     retire_stale;

    assign stale_pending = |stale_cnt_q;

    // only one fetch is ever in flight, so a nonzero count means it is
    // already marked and a second redirect must not count it twice.
    // data returning in the redirect cycle itself is killed by the stage
    assign mark_stale = redirect_now & inflight & ~isram_data_ok & ~stale_pending;

    // stale data comes back in order, one pulse per marked fetch
    assign retire_stale = isram_data_ok & stale_pending;

    assign resp_drop = retire_stale;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            stale_cnt_q <= '0;
        end else if (mark_stale) begin
            stale_cnt_q <= stale_cnt_q + OUTSTANDING_W'(1);
        end else if (retire_stale) begin
            stale_cnt_q <= stale_cnt_q - OUTSTANDING_W'(1);
        end
    end

endmodule

// File: src/fetch_pkg.sv
package fetch_pkg;

    localparam int PC_W   = 32;
    localparam int INST_W = 32;

    // program counter or fetch address
    typedef logic [PC_W-1:0]   pc_t;

    // raw instruction word as handed to decode
    typedef logic [INST_W-1:0] inst_t;

    // sequential fetch stride
    localparam pc_t PC_STEP = 32'h0000_0004;

    // one word below the boot vector, so the first sequential fetch lands on it
    localparam pc_t RESET_PC = 32'h1BFF_FFFC;

    // which kind of redirect is waiting for the SRAM to take its target
    typedef enum logic [1:0] {
        REDIR_IDLE   = 2'b00,
        REDIR_BRANCH = 2'b01,
        REDIR_WB     = 2'b10
    } redirect_state_t;

endpackage

// File: src/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
    input  logic                   clk,
    input  logic                   resetn,
    // instruction SRAM read port
    output logic                   isram_req,
    output isram_pkg::isram_addr_t isram_addr,
    input  logic                   isram_addr_ok,
    input  logic                   isram_data_ok,
    input  isram_pkg::isram_data_t isram_rdata,
    // redirect and cancel control
    input  logic                   redirect_active,
    input  logic                   redirect_now,
    input  fetch_pkg::pc_t         redirect_target,
    input  logic                   resp_drop,
    input  logic                   wb_flush,
    output logic                   addr_fire,
    output logic                   inflight,
    // link to decode
    output logic                   out_valid,
    input  logic                   out_ready,
    output fetch_pkg::pc_t         out_pc,
    output fetch_pkg::inst_t       out_inst,
    output logic                   out_adef
);
    import fetch_pkg::*;

    logic  fetch_en_q;
    pc_t   pc_q;
    pc_t   seq_pc;
    pc_t   next_pc;
    logic  inflight_q;
    logic  adef_q;
    logic  buf_valid_q;
    inst_t buf_inst_q;

    logic  kill;
    logic  data_kept;
    logic  word_avail;
    logic  deliver;
    logic  hold_word;
    logic  slot_free;

    // next address: redirect target wins, otherwise sequential
    assign seq_pc  = pc_q + PC_STEP;
    assign next_pc = redirect_active ? redirect_target : seq_pc;

    // anything shown or returning this cycle is wrong path
    assign kill = redirect_now | wb_flush;

    // the in-flight fetch returns and does not belong to a stale request
    assign data_kept  = inflight_q & isram_data_ok & ~resp_drop;
    assign word_avail = buf_valid_q | data_kept;

    assign out_valid = word_avail & ~kill;
    assign deliver   = out_valid & out_ready;

    // word that decode did not take this cycle stays in the buffer
    assign hold_word = word_avail & ~deliver & ~kill;

    // SRAM side has room when nothing is in flight or it returns now
    assign slot_free = ~inflight_q | isram_data_ok;

    assign isram_req  = fetch_en_q & slot_free & ~hold_word;
    assign isram_addr = next_pc;
    assign addr_fire  = isram_req & isram_addr_ok;
    assign inflight   = inflight_q;

    // pc_q only moves on addr_fire, which cannot happen while a word waits
    assign out_pc   = pc_q;
    assign out_inst = buf_valid_q ? buf_inst_q : isram_rdata;
    assign out_adef = adef_q;

    // first request goes out one cycle after reset is released
    always_ff @(posedge clk) begin
        if (!resetn) begin
            fetch_en_q <= 1'b0;
        end else begin
            fetch_en_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pc_q       <= RESET_PC;
            inflight_q <= 1'b0;
        end else if (addr_fire) begin
            pc_q       <= next_pc;
            inflight_q <= 1'b1;
        end else if (isram_data_ok) begin
            inflight_q <= 1'b0;
        end
    end

    // misaligned fetch address, reported to decode with the word
    always_ff @(posedge clk) begin
        if (addr_fire) begin
            adef_q <= |next_pc[1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            buf_valid_q <= 1'b0;
        end else begin
            buf_valid_q <= hold_word;
        end
    end

    always_ff @(posedge clk) begin
        if (data_kept && !buf_valid_q) begin
            buf_inst_q <= isram_rdata;
        end
    end

endmodule

// File: src/fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
    input  logic                   clk,
    input  logic                   resetn,
    // instruction SRAM read port
    output logic                   isram_req,
    output isram_pkg::isram_addr_t isram_addr,
    input  logic                   isram_addr_ok,
    input  logic                   isram_data_ok,
    input  isram_pkg::isram_data_t isram_rdata,
    // decode link
    output logic                   out_valid,
    input  logic                   out_ready,
    output fetch_pkg::pc_t         out_pc,
    output fetch_pkg::inst_t       out_inst,
    output logic                   out_adef,
    // redirect sources
    input  logic                   br_taken,
    input  fetch_pkg::pc_t         br_target,
    input  logic                   wb_redirect,
    input  fetch_pkg::pc_t         wb_target,
    input  logic                   wb_flush
);
    import fetch_pkg::*;

    logic redirect_active;
    logic redirect_now;
    pc_t  redirect_target;
    logic addr_fire;
    logic inflight;
    logic resp_drop;

    redirect_hold redirect_hold_i (
        .clk             (clk),
        .resetn          (resetn),
        .br_taken        (br_taken),
        .br_target       (br_target),
        .wb_redirect     (wb_redirect),
        .wb_target       (wb_target),
        .addr_fire       (addr_fire),
        .redirect_active (redirect_active),
        .redirect_now    (redirect_now),
        .redirect_target (redirect_target)
    );

    fetch_cancel fetch_cancel_i (
        .clk           (clk),
        .resetn        (resetn),
        .redirect_now  (redirect_now),
        .inflight      (inflight),
        .isram_data_ok (isram_data_ok),
        .resp_drop     (resp_drop)
    );

    fetch_stage fetch_stage_i (
        .clk             (clk),
        .resetn          (resetn),
        .isram_req       (isram_req),
        .isram_addr      (isram_addr),
        .isram_addr_ok   (isram_addr_ok),
        .isram_data_ok   (isram_data_ok),
        .isram_rdata     (isram_rdata),
        .redirect_active (redirect_active),
        .redirect_now    (redirect_now),
        .redirect_target (redirect_target),
        .resp_drop       (resp_drop),
        .wb_flush        (wb_flush),
        .addr_fire       (addr_fire),
        .inflight        (inflight),
        .out_valid       (out_valid),
        .out_ready       (out_ready),
        .out_pc          (out_pc),
        .out_inst        (out_inst),
        .out_adef        (out_adef)
    );

endmodule

// File: src/isram_pkg.sv
package isram_pkg;

    localparam int ISRAM_ADDR_W = 32;
    localparam int ISRAM_DATA_W = 32;

    // word read address presented in the address phase
    typedef logic [ISRAM_ADDR_W-1:0] isram_addr_t;

    // read data returned in the data phase
    typedef logic [ISRAM_DATA_W-1:0] isram_data_t;

    // width of the counter of fetches whose data must be thrown away
    localparam int OUTSTANDING_W = 4;

endpackage

// File: src/redirect_hold.sv
`timescale 1ns/1ps

module redirect_hold (
    input  logic           clk,
    input  logic           resetn,
    // branch resolved in decode
    input  logic           br_taken,
    input  fetch_pkg::pc_t br_target,
    // exception entry or return from write-back
    input  logic           wb_redirect,
    input  fetch_pkg::pc_t wb_target,
    // SRAM took the address this cycle
    input  logic           addr_fire,
    output logic           redirect_active,
    output logic           redirect_now,
    output fetch_pkg::pc_t redirect_target
);
    import fetch_pkg::*;

    redirect_state_t state_q;
    redirect_state_t state_d;
    pc_t             target_q;
    pc_t             target_d;
    logic            br_accept;

    // a branch from decode is moot once a write-back redirect is pending
    assign br_accept = br_taken & (state_q != REDIR_WB);

    assign redirect_now    = wb_redirect | br_accept;
    assign redirect_active = redirect_now | (state_q != REDIR_IDLE);

    always_comb begin
        state_d  = state_q;
        target_d = target_q;

        if (wb_redirect) begin
            state_d  = REDIR_WB;
            target_d = wb_target;
        end else if (br_accept) begin
            state_d  = REDIR_BRANCH;
            target_d = br_target;
        end

        // the redirected address went out, live or held
        if (addr_fire) begin
            state_d = REDIR_IDLE;
        end
    end

    // live target goes straight to the address mux, else the held one
    assign redirect_target = target_d;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state_q <= REDIR_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        target_q <= target_d;
    end

endmodule

// File: verification/fetch_checker.sv
`timescale 1ns/1ps

module fetch_checker (
    input logic             clk,
    input logic             resetn,
    input logic             isram_req,
    input logic             isram_data_ok,
    input logic             out_valid,
    input logic             out_ready,
    input fetch_pkg::pc_t   out_pc,
    input fetch_pkg::inst_t out_inst,
    input logic             out_adef,
    input logic             redirect_now,
    input logic             wb_flush,
    input logic             resp_drop
);
    int   fail_count = 0;
    logic reset_seen = 1'b0;

    // flops only hold known values once one reset edge has gone by
    always @(posedge clk) begin
        if (!resetn) begin
            reset_seen <= 1'b1;
        end
    end

    quiet_in_reset: assert property (@(posedge clk)
        (!resetn && reset_seen) |-> (!out_valid && !isram_req))
        else begin
            $error("out_valid or isram_req high during reset");
            fail_count++;
        end

    // a stalled word keeps its pc, instruction and exception flag
    hold_under_stall: assert property (@(posedge clk) disable iff (!resetn)
        (out_valid && !out_ready && !redirect_now && !wb_flush) |=>
            ($stable(out_pc) && $stable(out_inst) && $stable(out_adef)))
        else begin
            $error("decode outputs changed while stalled");
            fail_count++;
        end

    // a dropped word comes with its data pulse and never reaches decode
    drop_needs_data: assert property (@(posedge clk) disable iff (!resetn)
        resp_drop |-> (isram_data_ok && !out_valid))
        else begin
            $error("resp_drop without isram_data_ok or with out_valid high");
            fail_count++;
        end

endmodule

// File: verification/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb;
    import fetch_pkg::*;
    import isram_pkg::*;

    // every SRAM word is its own address XOR this pattern
    localparam logic [31:0] PATTERN = 32'h5A3C_96E1;
    localparam logic [31:0] SEED    = 32'h93F8_8941;

    logic        clk = 1'b0;
    logic        resetn = 1'b0;
    logic        isram_req;
    isram_addr_t isram_addr;
    logic        isram_addr_ok = 1'b0;
    logic        isram_data_ok = 1'b0;
    isram_data_t isram_rdata = '0;
    logic        out_valid;
    logic        out_ready = 1'b0;
    pc_t         out_pc;
    inst_t       out_inst;
    logic        out_adef;
    logic        br_taken = 1'b0;
    pc_t         br_target = '0;
    logic        wb_redirect = 1'b0;
    pc_t         wb_target = '0;
    logic        wb_flush = 1'b0;

    int          error_count = 0;
    int          check_count = 0;
    int          word_count = 0;
    pc_t         exp_pc;
    logic        last_valid = 1'b0;
    pc_t         last_pc;
    logic [31:0] tb_lcg = SEED;
    logic [31:0] mem_lcg = SEED;
    int          cycle = 0;
    isram_addr_t req_addr_q[$];
    int          req_due_q[$];

    always #10 clk = ~clk;

    fetch_top fetch_top_i (
        .clk           (clk),
        .resetn        (resetn),
        .isram_req     (isram_req),
        .isram_addr    (isram_addr),
        .isram_addr_ok (isram_addr_ok),
        .isram_data_ok (isram_data_ok),
        .isram_rdata   (isram_rdata),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .out_pc        (out_pc),
        .out_inst      (out_inst),
        .out_adef      (out_adef),
        .br_taken      (br_taken),
        .br_target     (br_target),
        .wb_redirect   (wb_redirect),
        .wb_target     (wb_target),
        .wb_flush      (wb_flush)
    );

    bind fetch_top fetch_checker fetch_checker_i (
        .clk           (clk),
        .resetn        (resetn),
        .isram_req     (isram_req),
        .isram_data_ok (isram_data_ok),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .out_pc        (out_pc),
        .out_inst      (out_inst),
        .out_adef      (out_adef),
        .redirect_now  (redirect_now),
        .wb_flush      (wb_flush),
        .resp_drop     (resp_drop)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // SRAM model: random address acceptance, in-order data 1 to 4 cycles later
    always @(posedge clk) begin
        if (!resetn) begin
            isram_addr_ok <= 1'b0;
            isram_data_ok <= 1'b0;
            mem_lcg = SEED;
            cycle = 0;
            req_addr_q.delete();
            req_due_q.delete();
        end else begin
            cycle = cycle + 1;
            mem_lcg = lcg_next(mem_lcg);
            if (isram_req && isram_addr_ok) begin
                req_addr_q.push_back(isram_addr);
                req_due_q.push_back(cycle + int'(mem_lcg[17:16]));
            end
            isram_addr_ok <= (mem_lcg[31:30] != 2'b00);
            isram_data_ok <= 1'b0;
            if (req_due_q.size() > 0 && req_due_q[0] <= cycle) begin
                isram_data_ok <= 1'b1;
                isram_rdata   <= req_addr_q[0] ^ PATTERN;
                void'(req_addr_q.pop_front());
                void'(req_due_q.pop_front());
            end
        end
    end

    task automatic check_pc(input pc_t actual, input pc_t expected, input string name);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic check_inst(input inst_t actual, input inst_t expected, input string name);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string name);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s = %b, expected %b", $time, name, actual, expected);
        end
    endtask

    // one clock edge; scores the decode transfer that completed on it
    task automatic tick();
        @(posedge clk);
        last_valid = out_valid;
        last_pc    = out_pc;
        if (resetn && out_valid && out_ready) begin
            word_count++;
            check_pc(out_pc, exp_pc, "out_pc");
            check_inst(out_inst, exp_pc ^ PATTERN, "out_inst");
            check_flag(out_adef, exp_pc[1:0] != 2'b00, "out_adef");
            exp_pc = exp_pc + 32'd4;
        end
    endtask

    task automatic run_words(input int count, input bit random_ready);
        int target;
        int waited;
        target = word_count + count;
        waited = 0;
        while (word_count < target && waited < count * 30) begin
            if (random_ready) begin
                tb_lcg = lcg_next(tb_lcg);
                out_ready <= tb_lcg[31];
            end else begin
                out_ready <= 1'b1;
            end
            tick();
            waited++;
        end
        out_ready <= 1'b1;
        if (word_count < target) begin
            error_count++;
            $display("timeout at %0t: decode got %0d of %0d words", $time,
                     count - (target - word_count), count);
        end
    endtask

    task automatic branch_to(input pc_t target, input int count, input bit random_ready);
        br_taken  <= 1'b1;
        br_target <= target;
        tick();
        br_taken <= 1'b0;
        exp_pc = target;
        run_words(count, random_ready);
    endtask

    task automatic wb_over_branch();
        // same cycle, different targets
        br_taken    <= 1'b1;
        br_target   <= 32'h1C00_5000;
        wb_redirect <= 1'b1;
        wb_target   <= 32'h1FC0_0380;
        tick();
        br_taken    <= 1'b0;
        wb_redirect <= 1'b0;
        exp_pc = 32'h1FC0_0380;
        run_words(6, 1'b0);
        // write-back one cycle after a branch that may still be held
        br_taken  <= 1'b1;
        br_target <= 32'h1C00_5800;
        tick();
        br_taken    <= 1'b0;
        wb_redirect <= 1'b1;
        wb_target   <= 32'h1FC0_0400;
        tick();
        wb_redirect <= 1'b0;
        exp_pc = 32'h1FC0_0400;
        run_words(6, 1'b1);
    endtask

    task automatic flush_held_word();
        int waited;
        out_ready <= 1'b0;
        waited = 0;
        last_valid = 1'b0;
        while (!last_valid && waited < 50) begin
            tick();
            waited++;
        end
        if (!last_valid) begin
            error_count++;
            $display("timeout at %0t: no word reached decode before the flush", $time);
        end
        check_pc(last_pc, exp_pc, "held out_pc");
        wb_flush <= 1'b1;
        tick();
        wb_flush <= 1'b0;
        check_flag(last_valid, 1'b0, "out_valid during flush");
        // the held word is gone, fetch carries on behind it
        exp_pc = exp_pc + 32'd4;
        run_words(4, 1'b0);
    endtask

    initial begin
        repeat (2) tick();
        resetn    <= 1'b1;
        out_ready <= 1'b1;
        exp_pc = 32'h1C00_0000;
        run_words(16, 1'b0);
        run_words(24, 1'b1);
        branch_to(32'h1C00_2000, 5, 1'b0);
        branch_to(32'h1C00_3000, 5, 1'b1);
        branch_to(32'h1C00_4010, 5, 1'b1);
        wb_over_branch();
        flush_held_word();
        // misaligned target raises out_adef
        branch_to(32'h1C00_6002, 3, 1'b0);
        branch_to(32'h1C00_7000, 3, 1'b0);
        $display("checks: %0d, errors: %0d, assertion failures: %0d, words: %0d",
                 check_count, error_count, fetch_top_i.fetch_checker_i.fail_count,
                 word_count);
        if (error_count == 0 && fetch_top_i.fetch_checker_i.fail_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
